/* verilog/gecko_pkg.sv */
package gecko_pkg;

    typedef logic [31:0] gecko_word_t;
    typedef logic [4:0] gecko_reg_addr_t;
    typedef logic [31:0] gecko_retired_count_t;

    //////////////////////////////////////////////////////////////////////
    // Operations and control states
    //////////////////////////////////////////////////////////////////////

    typedef enum logic [4:0] {
        OP_LUI,
        OP_ADDI,
        OP_ANDI,
        OP_ORI,
        OP_XORI,
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_LW,
        OP_SW,
        OP_BEQ,
        OP_BNE,
        OP_JAL,
        OP_ECALL,
        OP_ILLEGAL
    } gecko_op_t;

    typedef enum logic [2:0] {
        FETCH,
        FETCH_WAIT,
        DECODE,
        EXECUTE,
        MEM_WAIT,
        WRITEBACK,
        HALT
    } gecko_state_t;

    typedef struct packed {
        gecko_op_t op;
        gecko_reg_addr_t rd;
        gecko_reg_addr_t rs1;
        gecko_reg_addr_t rs2;
        gecko_word_t imm;
    } gecko_decoded_t;

    // Operations that put a value into rd.
    function automatic logic gecko_writes_rd(gecko_op_t op);
        return !(op inside {OP_SW, OP_BEQ, OP_BNE, OP_ECALL, OP_ILLEGAL});
    endfunction

    function automatic logic gecko_is_mem(gecko_op_t op);
        return (op == OP_LW) || (op == OP_SW);
    endfunction

endpackage

/* verilog/gecko_mem_if.sv */
`timescale 1ns/10ps

interface gecko_mem_if
    import gecko_pkg::*;
();

    logic req;
    logic write;
    gecko_word_t addr;
    gecko_word_t wdata;

    logic rvalid;
    gecko_word_t rdata;

    modport core (
        output req, write, addr, wdata,
        input rvalid, rdata
    );

    modport memory (
        input req, write, addr, wdata,
        output rvalid, rdata
    );

endinterface

/* verilog/gecko_control.sv */
`timescale 1ns/10ps

module gecko_control
    import gecko_pkg::*;
#(
    parameter gecko_word_t START_ADDR = '0
)(
    input logic clk, rst,

    gecko_mem_if.core inst_bus,
    gecko_mem_if.core data_bus,

    input gecko_decoded_t decoded,
    input gecko_word_t next_pc,
    input gecko_word_t mem_addr,
    input gecko_word_t store_data,

    output gecko_word_t instr,
    output gecko_word_t pc,
    output gecko_word_t load_data,

    output logic reg_write,
    output logic retire,
    output logic faulted_flag, finished_flag
);

    gecko_state_t state;

    logic inst_req_q;
    logic data_req_q;
    logic data_write_q;

    // Instruction side never writes.
    assign inst_bus.req = inst_req_q;
    assign inst_bus.write = 1'b0;
    assign inst_bus.addr = pc;
    assign inst_bus.wdata = '0;

    assign data_bus.req = data_req_q;
    assign data_bus.write = data_write_q;
    assign data_bus.addr = mem_addr;
    assign data_bus.wdata = store_data;

    assign retire = (state == WRITEBACK);
    assign reg_write = retire && gecko_writes_rd(decoded.op);

    //////////////////////////////////////////////////////////////////////
    // Sequencing
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= FETCH;
            pc <= START_ADDR;
            inst_req_q <= 1'b0;
            data_req_q <= 1'b0;
            data_write_q <= 1'b0;
            faulted_flag <= 1'b0;
            finished_flag <= 1'b0;
        end else begin
            // Strobes last one cycle.
            inst_req_q <= 1'b0;
            data_req_q <= 1'b0;
            data_write_q <= 1'b0;

            case (state)
            FETCH: begin
                // Out of reset the strobe is raised here first.
                if (inst_req_q) begin
                    state <= FETCH_WAIT;
                end else begin
                    inst_req_q <= 1'b1;
                end
            end
            FETCH_WAIT: begin
                if (inst_bus.rvalid) begin
                    state <= DECODE;
                end
            end
            DECODE: begin
                if (decoded.op == OP_ILLEGAL) begin
                    state <= HALT;
                    faulted_flag <= 1'b1;
                end else begin
                    state <= EXECUTE;
                    data_req_q <= gecko_is_mem(decoded.op);
                    data_write_q <= (decoded.op == OP_SW);
                end
            end
            EXECUTE: begin
                state <= gecko_is_mem(decoded.op) ? MEM_WAIT : WRITEBACK;
            end
            MEM_WAIT: begin
                if (data_bus.rvalid) begin
                    state <= WRITEBACK;
                end
            end
            WRITEBACK: begin
                pc <= next_pc;
                if (decoded.op == OP_ECALL) begin
                    state <= HALT;
                    finished_flag <= 1'b1;
                end else begin
                    state <= FETCH;
                    inst_req_q <= 1'b1;
                end
            end
            default: begin
                state <= HALT;
            end
            endcase
        end
    end

    // Fetched instruction and loaded word.
    always_ff @(posedge clk) begin
        if (state == FETCH_WAIT && inst_bus.rvalid) begin
            instr <= inst_bus.rdata;
        end
        if (state == MEM_WAIT && data_bus.rvalid) begin
            load_data <= data_bus.rdata;
        end
    end

endmodule

/* verilog/gecko_retire_counter.sv */
`timescale 1ns/10ps

module gecko_retire_counter #(
    parameter int COUNT_WIDTH = 32
)(
    input logic clk, rst,

    input logic retire,

    output logic [COUNT_WIDTH-1:0] count
);

    logic saturated;

    assign saturated = &count;

    // Holds at all ones.
    always_ff @(posedge clk) begin
        if (rst) begin
            count <= '0;
        end else if (retire && !saturated) begin
            count <= count + 1'b1;
        end
    end

endmodule

/* verilog/gecko_decode.sv */
`timescale 1ns/10ps

module gecko_decode
    import gecko_pkg::*;
(
    input gecko_word_t instr,

    output gecko_decoded_t decoded
);

    typedef enum logic [6:0] {
        MAJOR_LUI = 7'b0110111,
        MAJOR_OP_IMM = 7'b0010011,
        MAJOR_OP = 7'b0110011,
        MAJOR_LOAD = 7'b0000011,
        MAJOR_STORE = 7'b0100011,
        MAJOR_BRANCH = 7'b1100011,
        MAJOR_JAL = 7'b1101111,
        MAJOR_SYSTEM = 7'b1110011
    } major_t;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    gecko_word_t imm_i, imm_s, imm_b, imm_u, imm_j;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    assign decoded.rd = instr[11:7];
    assign decoded.rs1 = instr[19:15];
    assign decoded.rs2 = instr[24:20];

    always_comb begin
        decoded.op = OP_ILLEGAL;
        decoded.imm = imm_i;

        case (opcode)
        MAJOR_LUI: begin
            decoded.op = OP_LUI;
            decoded.imm = imm_u;
        end
        MAJOR_OP_IMM: begin
            case (funct3)
            3'b000: decoded.op = OP_ADDI;
            3'b111: decoded.op = OP_ANDI;
            3'b110: decoded.op = OP_ORI;
            3'b100: decoded.op = OP_XORI;
            default: decoded.op = OP_ILLEGAL;
            endcase
        end
        MAJOR_OP: begin
            case ({funct7, funct3})
            {7'b0000000, 3'b000}: decoded.op = OP_ADD;
            {7'b0100000, 3'b000}: decoded.op = OP_SUB;
            {7'b0000000, 3'b111}: decoded.op = OP_AND;
            {7'b0000000, 3'b110}: decoded.op = OP_OR;
            {7'b0000000, 3'b100}: decoded.op = OP_XOR;
            default: decoded.op = OP_ILLEGAL;
            endcase
        end
        MAJOR_LOAD: begin
            if (funct3 == 3'b010) decoded.op = OP_LW;
        end
        MAJOR_STORE: begin
            if (funct3 == 3'b010) decoded.op = OP_SW;
            decoded.imm = imm_s;
        end
        MAJOR_BRANCH: begin
            if (funct3 == 3'b000) decoded.op = OP_BEQ;
            if (funct3 == 3'b001) decoded.op = OP_BNE;
            decoded.imm = imm_b;
        end
        MAJOR_JAL: begin
            decoded.op = OP_JAL;
            decoded.imm = imm_j;
        end
        MAJOR_SYSTEM: begin
            // Only the exact ECALL word.
            if (instr[31:7] == '0) decoded.op = OP_ECALL;
        end
        default: decoded.op = OP_ILLEGAL;
        endcase
    end

endmodule

/* verilog/gecko_execute.sv */
`timescale 1ns/10ps

module gecko_execute
    import gecko_pkg::*;
(
    input gecko_decoded_t decoded,
    input gecko_word_t pc,

    input gecko_word_t rs1_value,
    input gecko_word_t rs2_value,
    input gecko_word_t load_data,

    output gecko_word_t result,
    output gecko_word_t next_pc,
    output gecko_word_t mem_addr,
    output gecko_word_t store_data
);

    gecko_word_t pc_plus_4;
    gecko_word_t target;
    logic equal;

    assign pc_plus_4 = pc + 32'd4;
    assign target = pc + decoded.imm;
    assign equal = (rs1_value == rs2_value);

    assign mem_addr = rs1_value + decoded.imm;
    assign store_data = rs2_value;

    //////////////////////////////////////////////////////////////////////
    // ALU
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        case (decoded.op)
        OP_LUI: result = decoded.imm;
        OP_ADDI: result = rs1_value + decoded.imm;
        OP_ANDI: result = rs1_value & decoded.imm;
        OP_ORI: result = rs1_value | decoded.imm;
        OP_XORI: result = rs1_value ^ decoded.imm;
        OP_ADD: result = rs1_value + rs2_value;
        OP_SUB: result = rs1_value - rs2_value;
        OP_AND: result = rs1_value & rs2_value;
        OP_OR: result = rs1_value | rs2_value;
        OP_XOR: result = rs1_value ^ rs2_value;
        OP_LW: result = load_data;
        // Link address.
        OP_JAL: result = pc_plus_4;
        default: result = '0;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // Next PC
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        case (decoded.op)
        OP_BEQ: next_pc = equal ? target : pc_plus_4;
        OP_BNE: next_pc = equal ? pc_plus_4 : target;
        OP_JAL: next_pc = target;
        default: next_pc = pc_plus_4;
        endcase
    end

endmodule

/* verilog/gecko_regfile.sv */
`timescale 1ns/10ps

module gecko_regfile
    import gecko_pkg::*;
(
    input logic clk, rst,

    input gecko_reg_addr_t rs1,
    input gecko_reg_addr_t rs2,
    output gecko_word_t rs1_value,
    output gecko_word_t rs2_value,

    input logic write_enable,
    input gecko_reg_addr_t rd,
    input gecko_word_t rd_value
);

    gecko_word_t regs [32];

    assign rs1_value = regs[rs1];
    assign rs2_value = regs[rs2];

    // x0 is never written, so it stays zero.
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (write_enable && rd != '0) begin
            regs[rd] <= rd_value;
        end
    end

endmodule

/* verilog/gecko_core.sv */
`timescale 1ns/10ps

module gecko_core
    import gecko_pkg::*;
#(
    parameter gecko_word_t START_ADDR = '0,
    parameter int COUNT_WIDTH = 32
)(
    input logic clk, rst,

    output logic inst_req,
    output gecko_word_t inst_addr,
    input logic inst_rvalid,
    input gecko_word_t inst_rdata,

    output logic data_req,
    output logic data_write,
    output gecko_word_t data_addr,
    output gecko_word_t data_wdata,
    input logic data_rvalid,
    input gecko_word_t data_rdata,

    output logic faulted_flag, finished_flag,
    output gecko_retired_count_t retired_count
);

    gecko_mem_if inst_bus ();
    gecko_mem_if data_bus ();

    gecko_decoded_t decoded;
    gecko_word_t instr, pc, next_pc;
    gecko_word_t mem_addr, store_data, load_data;
    gecko_word_t rs1_value, rs2_value, result;
    logic reg_write, retire;
    logic [COUNT_WIDTH-1:0] count;

    //////////////////////////////////////////////////////////////////////
    // Memory buses to top-level ports
    //////////////////////////////////////////////////////////////////////

    assign inst_req = inst_bus.req;
    assign inst_addr = inst_bus.addr;
    assign inst_bus.rvalid = inst_rvalid;
    assign inst_bus.rdata = inst_rdata;

    assign data_req = data_bus.req;
    assign data_write = data_bus.write;
    assign data_addr = data_bus.addr;
    assign data_wdata = data_bus.wdata;
    assign data_bus.rvalid = data_rvalid;
    assign data_bus.rdata = data_rdata;

    assign retired_count = gecko_retired_count_t'(count);

    gecko_control #(
        .START_ADDR(START_ADDR)
    ) gecko_control_inst (
        .clk, .rst,
        .inst_bus, .data_bus,
        .decoded, .next_pc, .mem_addr, .store_data,
        .instr, .pc, .load_data,
        .reg_write, .retire,
        .faulted_flag, .finished_flag
    );

    gecko_decode gecko_decode_inst (
        .instr, .decoded
    );

    gecko_regfile gecko_regfile_inst (
        .clk, .rst,
        .rs1(decoded.rs1), .rs2(decoded.rs2),
        .rs1_value, .rs2_value,
        .write_enable(reg_write), .rd(decoded.rd), .rd_value(result)
    );

    gecko_execute gecko_execute_inst (
        .decoded, .pc,
        .rs1_value, .rs2_value, .load_data,
        .result, .next_pc, .mem_addr, .store_data
    );

    gecko_retire_counter #(
        .COUNT_WIDTH(COUNT_WIDTH)
    ) gecko_retire_counter_inst (
        .clk, .rst,
        .retire, .count
    );

endmodule

/* tests/gecko_core_tb.sv */
`timescale 1ns/10ps

module gecko_core_tb
    import gecko_pkg::*;
();

    localparam int PROGRAMS = 2;
    localparam int TESTDATA_WORDS = 68;
    localparam int MEM_WORDS = 64;
    localparam int MAX_LATENCY = 4;
    localparam int CYCLES_PER_WORD = 6 + 2 * MAX_LATENCY;

    logic clk, rst;
    logic inst_req, inst_rvalid;
    gecko_word_t inst_addr, inst_rdata;
    logic data_req, data_write, data_rvalid;
    gecko_word_t data_addr, data_wdata, data_rdata;
    logic faulted_flag, finished_flag;
    gecko_retired_count_t retired_count;

    gecko_word_t testdata [TESTDATA_WORDS];
    gecko_word_t imem [MEM_WORDS];
    gecko_word_t dmem [MEM_WORDS];
    gecko_word_t exp_addr [$];
    gecko_word_t exp_data [$];
    int data_pos;
    int store_index;
    string test_name;
    logic [7:0] lfsr_state = 8'd62;
    int cycle_count;
    int timeout_limit;

    gecko_core #(
        .START_ADDR(gecko_word_t'(0)),
        .COUNT_WIDTH(32)
    ) u_gecko_core (
        .clk, .rst,
        .inst_req, .inst_addr, .inst_rvalid, .inst_rdata,
        .data_req, .data_write, .data_addr, .data_wdata, .data_rvalid, .data_rdata,
        .faulted_flag, .finished_flag, .retired_count
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (timeout_limit > 0 && cycle_count >= timeout_limit) begin
            $display("Timeout: the core did not halt within %0d cycles", timeout_limit);
            $display("Done: errors found");
            $fatal(1);
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Checks and random latency
    //////////////////////////////////////////////////////////////////////

    task automatic stop_with_failure();
        $display("Done: errors found");
        $fatal(1);
    endtask

    task automatic check_word(string name, gecko_word_t expected, gecko_word_t actual);
        if (actual !== expected) begin
            $display("[FAIL] %s: expected %08h, actual %08h", name, expected, actual);
            stop_with_failure();
        end
    endtask

    task automatic check_count(string name, gecko_retired_count_t expected,
                               gecko_retired_count_t actual);
        if (actual !== expected) begin
            $display("[FAIL] %s: expected %0d, actual %0d", name, expected, actual);
            stop_with_failure();
        end
    endtask

    task automatic check_flag(string name, logic expected, logic actual);
        if (actual !== expected) begin
            $display("[FAIL] %s: expected %0b, actual %0b", name, expected, actual);
            stop_with_failure();
        end
    endtask

    // Galois LFSR with taps for x^8 + x^6 + x^5 + x^4 + 1.
    function automatic logic next_random_bit();
        logic out_bit;
        out_bit = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (out_bit) begin
            lfsr_state = lfsr_state ^ 8'hB8;
        end
        return out_bit;
    endfunction

    function automatic int draw_latency();
        int latency;
        latency = 1 + 2 * int'(next_random_bit());
        latency = latency + int'(next_random_bit());
        return latency;
    endfunction

    task automatic record_store(gecko_word_t addr, gecko_word_t wdata);
        if (store_index >= exp_addr.size()) begin
            $display("%s made a store beyond the expected list, to address %08h",
                     test_name, addr);
            stop_with_failure();
        end else begin
            check_word($sformatf("%s store %0d address", test_name, store_index),
                       exp_addr[store_index], addr);
            check_word($sformatf("%s store %0d data", test_name, store_index),
                       exp_data[store_index], wdata);
            store_index++;
            dmem[addr >> 2] = wdata;
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Memory model for both buses
    //////////////////////////////////////////////////////////////////////

    initial begin
        int latency;
        logic serve_inst;
        gecko_word_t req_addr;
        inst_rvalid = 1'b0;
        inst_rdata = '0;
        data_rvalid = 1'b0;
        data_rdata = '0;
        forever begin
            @(negedge clk);
            if (!rst && (inst_req || data_req)) begin
                serve_inst = inst_req;
                req_addr = serve_inst ? inst_addr : data_addr;
                if (req_addr >= MEM_WORDS * 4) begin
                    $display("%s requested address %08h outside the memory", test_name,
                             req_addr);
                    stop_with_failure();
                end else if (!serve_inst && data_write) begin
                    record_store(req_addr, data_wdata);
                end
                latency = draw_latency();
                repeat (latency) @(posedge clk);
                if (serve_inst) begin
                    inst_rdata <= imem[req_addr >> 2];
                    inst_rvalid <= 1'b1;
                end else begin
                    data_rdata <= dmem[req_addr >> 2];
                    data_rvalid <= 1'b1;
                end
                @(posedge clk);
                inst_rvalid <= 1'b0;
                data_rvalid <= 1'b0;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Program sequencing
    //////////////////////////////////////////////////////////////////////

    task automatic apply_reset(string label);
        @(posedge clk);
        rst <= 1'b1;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_flag({label, " faulted_flag after reset"}, 1'b0, faulted_flag);
        check_flag({label, " finished_flag after reset"}, 1'b0, finished_flag);
        check_count({label, " retired_count after reset"}, '0, retired_count);
    endtask

    task automatic run_program(int number);
        int words;
        int stores;
        gecko_retired_count_t expected_retired;
        logic expect_fault;
        words = int'(testdata[data_pos]);
        for (int i = 0; i < MEM_WORDS; i++) begin
            // Unused words hold their address over an all-zero opcode.
            imem[i] = (i < words) ? testdata[data_pos + 1 + i] : gecko_word_t'(i * 4) << 7;
            dmem[i] = ~(gecko_word_t'(i) << 2);
        end
        data_pos += 1 + words;
        stores = int'(testdata[data_pos]);
        data_pos++;
        exp_addr.delete();
        exp_data.delete();
        for (int i = 0; i < stores; i++) begin
            exp_addr.push_back(testdata[data_pos]);
            exp_data.push_back(testdata[data_pos + 1]);
            data_pos += 2;
        end
        expected_retired = testdata[data_pos];
        expect_fault = testdata[data_pos + 1][0];
        data_pos += 2;
        store_index = 0;
        test_name = $sformatf("program %0d", number);

        apply_reset(test_name);
        while (!finished_flag && !faulted_flag) begin
            @(negedge clk);
        end
        check_flag({test_name, " finished_flag"}, !expect_fault, finished_flag);
        check_flag({test_name, " faulted_flag"}, expect_fault, faulted_flag);
        check_count({test_name, " retired_count"}, expected_retired, retired_count);
        if (store_index != stores) begin
            $display("%s made %0d stores where %0d were expected", test_name, store_index,
                     stores);
            stop_with_failure();
        end
        // Halted core stays quiet on both buses.
        repeat (20) begin
            @(negedge clk);
            if (inst_req || data_req) begin
                $display("%s issued a memory request after halting", test_name);
                stop_with_failure();
            end
        end
    endtask

    initial begin
        int total_words;
        int scan;
        rst = 1'b1;
        $readmemh("tests/gecko_core_testdata.txt", testdata);
        total_words = 0;
        scan = 0;
        for (int p = 0; p < PROGRAMS; p++) begin
            total_words += int'(testdata[scan]);
            scan += 1 + int'(testdata[scan]);
            scan += 3 + 2 * int'(testdata[scan]);
        end
        timeout_limit = total_words * CYCLES_PER_WORD + 100;

        data_pos = 0;
        for (int p = 1; p <= PROGRAMS; p++) begin
            run_program(p);
        end
        // Fault flag of the last program must clear.
        apply_reset("final");
        $display("Done: no errors");
        $finish;
    end

endmodule

/* flist.f */
verilog/gecko_pkg.sv
verilog/gecko_mem_if.sv
verilog/gecko_control.sv
verilog/gecko_retire_counter.sv
verilog/gecko_decode.sv
verilog/gecko_execute.sv
verilog/gecko_regfile.sv
verilog/gecko_core.sv
tests/gecko_core_tb.sv

/* Bender.yml */
package:
  name: gecko_core

sources:
  - target: rtl
    files:
      - verilog/gecko_pkg.sv
      - verilog/gecko_mem_if.sv
      - verilog/gecko_control.sv
      - verilog/gecko_retire_counter.sv
      - verilog/gecko_decode.sv
      - verilog/gecko_execute.sv
      - verilog/gecko_regfile.sv
      - verilog/gecko_core.sv

  - target: test
    files:
      - tests/gecko_core_tb.sv

/* tests/gecko_core_testdata.txt */
// Per program: word count, program words, store count, stores as address/data pairs,
// expected retired count, expected end (0 = ECALL finish, 1 = illegal word fault).
// Program 1: ALU operations seen through SW, then LW and ECALL.
00000017
123450B7 67808093 0F00F193 5051E213 0FF24293
00508333 401283B3 0013F433 0051E4B3 00734533
00102023 00302223 00402423 00502623 00602823
00702A23 00802C23 00902E23 02A02023 00802583
00558633 02C02223 00000073
0000000A
00000000 12345678 00000004 00000070
00000008 00000575 0000000C 0000058A
00000010 12345C02 00000014 EDCBAF12
00000018 00000610 0000001C 000005FA
00000020 FFFFF310 00000024 00000AFF
00000017 00000000
// Program 2: BEQ, BNE and JAL taken and not taken, then an illegal word.
0000000D
00500093 00500113 00208463 00102023 00209463
00202223 00009463 00002423 00008463 008001EF
00002623 00302823 FFFFFFFF
00000002
00000004 00000005 00000010 00000028
00000009 00000001
